// File: src/sudoku_pkg.sv
`default_nettype none

package sudoku_pkg;

    localparam int CELLS = 81; // also the end-of-load address
    localparam int SIDE  = 9;  // row length and highest digit
    localparam int BOX   = 3;

    // 0..80 are cells, 81 marks the end
    typedef logic [6:0] cell_idx_t;

    typedef logic [3:0] digit_t; // 0 is blank

    typedef logic [6:0] list_ptr_t;

    // cell 0 sits in the low nibble
    typedef digit_t [CELLS-1:0] board_t;

    typedef enum logic [2:0] {
        ST_LOAD,
        ST_STEP,
        ST_CHECK,
        ST_SOLVED,
        ST_FAILED
    } engine_state_e;

    // codes seen by the host
    typedef enum logic [1:0] {
        STATUS_BUSY   = 2'd0,
        STATUS_FAILED = 2'd1,
        STATUS_SOLVED = 2'd2
    } status_e;

endpackage

`default_nettype wire

// File: src/grid_store.sv
`default_nettype none

module grid_store (
    input  wire                        clk,
    input  wire                        in_hps_rst,
    input  wire                        i_wr_en,
    input  wire sudoku_pkg::cell_idx_t i_wr_idx,
    input  wire sudoku_pkg::digit_t    i_wr_value,
    input  wire sudoku_pkg::cell_idx_t i_probe_idx,
    input  wire sudoku_pkg::cell_idx_t i_read_idx,
    input  wire                        i_export_en,
    output sudoku_pkg::digit_t         o_probe_value,
    output sudoku_pkg::board_t         o_board,
    output sudoku_pkg::digit_t         o_read_value
);
    import sudoku_pkg::*;

    board_t cells_q;
    logic   wr_hit;
    logic   probe_ok;
    logic   read_ok;

    assign wr_hit   = i_wr_en && (i_wr_idx < CELLS); // end marker never lands
    assign probe_ok = (i_probe_idx < CELLS);
    assign read_ok  = i_export_en && (i_read_idx < CELLS);

    always_ff @(posedge clk) begin
        if (in_hps_rst) begin
            cells_q <= '0;
        end else if (wr_hit) begin
            cells_q[i_wr_idx] <= i_wr_value;
        end
    end

    assign o_board = cells_q;

    assign o_probe_value = probe_ok ? cells_q[i_probe_idx] : '0;

    // readback only after a solve
    assign o_read_value = read_ok ? cells_q[i_read_idx] : '0;

endmodule

`default_nettype wire

// File: src/conflict_check.sv
`default_nettype none

module conflict_check (
    input  wire sudoku_pkg::board_t    i_board,
    input  wire sudoku_pkg::cell_idx_t i_probe_idx,
    output logic                       o_conflict
);
    import sudoku_pkg::*;

    digit_t          probe_digit;
    logic            probe_ok;
    logic [SIDE-1:0] row_hit;
    logic [SIDE-1:0] col_hit;
    logic [SIDE-1:0] box_hit;

    assign probe_ok    = (i_probe_idx < CELLS);
    assign probe_digit = probe_ok ? i_board[i_probe_idx] : '0;

    always_comb begin : peer_scan
        int row;
        int col;
        int box_r;
        int box_c;
        int r;
        int c;

        if (probe_ok) begin
            row = int'(i_probe_idx) / SIDE;
            col = int'(i_probe_idx) % SIDE;
        end else begin
            row = 0; // digit is 0 here anyway
            col = 0;
        end
        box_r = (row / BOX) * BOX;
        box_c = (col / BOX) * BOX;

        for (int k = 0; k < SIDE; k++) begin
            // same row, skip own column
            row_hit[k] = (k != col) && (i_board[row * SIDE + k] == probe_digit);

            // same column, skip own row
            col_hit[k] = (k != row) && (i_board[k * SIDE + col] == probe_digit);

            r = box_r + k / BOX;
            c = box_c + k % BOX;
            box_hit[k] = !((r == row) && (c == col)) &&
                         (i_board[r * SIDE + c] == probe_digit);
        end
    end

    // a blank probe never clashes
    assign o_conflict = (probe_digit != '0) && ((|row_hit) || (|col_hit) || (|box_hit));

endmodule

`default_nettype wire

// File: src/empty_cell_list.sv
`default_nettype none

module empty_cell_list (
    input  wire                        clk,
    input  wire                        in_hps_rst,
    input  wire                        i_append,
    input  wire sudoku_pkg::cell_idx_t i_append_idx,
    input  wire sudoku_pkg::list_ptr_t i_cursor,
    output sudoku_pkg::cell_idx_t      o_entry,
    output sudoku_pkg::list_ptr_t      o_count
);
    import sudoku_pkg::*;

    cell_idx_t slot_q [CELLS];
    list_ptr_t count_q;
    logic      push;
    logic      cursor_ok;

    assign push      = i_append && (count_q < CELLS);
    assign cursor_ok = (i_cursor < count_q);

    always_ff @(posedge clk) begin
        if (in_hps_rst) begin
            count_q <= '0;
        end else if (push) begin
            count_q <= count_q + list_ptr_t'(1);
        end
    end

    // blank positions in load order
    always_ff @(posedge clk) begin
        if (push) begin
            slot_q[count_q] <= i_append_idx;
        end
    end

    // unfilled slots read back as the end marker
    assign o_entry = cursor_ok ? slot_q[i_cursor] : cell_idx_t'(CELLS);
    assign o_count = count_q;

endmodule

`default_nettype wire

// File: src/backtrack_engine.sv
`default_nettype none

module backtrack_engine (
    input  wire                        clk,
    input  wire                        in_hps_rst,
    input  wire                        i_load_valid,
    input  wire sudoku_pkg::cell_idx_t i_load_addr,
    input  wire sudoku_pkg::digit_t    i_load_value,
    input  wire sudoku_pkg::list_ptr_t i_count,
    input  wire sudoku_pkg::cell_idx_t i_entry,
    input  wire sudoku_pkg::digit_t    i_probe_value,
    input  wire                        i_conflict,
    output logic                       o_append,
    output sudoku_pkg::list_ptr_t      o_cursor,
    output sudoku_pkg::cell_idx_t      o_probe_idx,
    output logic                       o_wr_en,
    output sudoku_pkg::cell_idx_t      o_wr_idx,
    output sudoku_pkg::digit_t         o_wr_value,
    output logic                       o_export_en,
    output sudoku_pkg::status_e        o_status
);
    import sudoku_pkg::*;

    engine_state_e state_q;
    engine_state_e state_d;
    list_ptr_t     cursor_q;
    list_ptr_t     cursor_d;
    logic          load_cell;
    logic          load_end;
    logic          digit_full;
    logic          last_entry;

    assign load_cell  = (state_q == ST_LOAD) && i_load_valid && (i_load_addr < CELLS);
    assign load_end   = (state_q == ST_LOAD) && i_load_valid && (i_load_addr == CELLS);
    assign digit_full = (i_probe_value >= digit_t'(SIDE)); // all digits tried
    assign last_entry = (cursor_q == i_count - list_ptr_t'(1));

    assign o_append    = load_cell && (i_load_value == '0);
    assign o_cursor    = cursor_q;
    assign o_probe_idx = i_entry; // the cell under trial
    assign o_export_en = (state_q == ST_SOLVED);

    // host load writes and search writes share one port
    always_comb begin
        o_wr_en    = 1'b0;
        o_wr_idx   = i_load_addr;
        o_wr_value = i_load_value;
        if (load_cell) begin
            o_wr_en = 1'b1;
        end else if (state_q == ST_STEP) begin
            o_wr_en  = 1'b1;
            o_wr_idx = i_entry;
            if (digit_full) begin
                o_wr_value = '0; // clear before stepping back
            end else begin
                o_wr_value = i_probe_value + digit_t'(1);
            end
        end
    end

    always_comb begin
        state_d  = state_q;
        cursor_d = cursor_q;
        case (state_q)
            ST_LOAD: begin
                if (load_end) begin
                    if (i_count == '0) begin
                        state_d = ST_SOLVED; // nothing to fill
                    end else begin
                        state_d = ST_STEP;
                    end
                end
            end
            ST_STEP: begin
                if (!digit_full) begin
                    state_d = ST_CHECK;
                end else if (cursor_q == '0) begin
                    state_d = ST_FAILED;
                end else begin
                    cursor_d = cursor_q - list_ptr_t'(1);
                end
            end
            ST_CHECK: begin
                // the written digit is visible on the board now
                if (i_conflict) begin
                    state_d = ST_STEP;
                end else if (last_entry) begin
                    state_d = ST_SOLVED;
                end else begin
                    cursor_d = cursor_q + list_ptr_t'(1);
                    state_d  = ST_STEP;
                end
            end
            default: begin
                state_d = state_q; // solved and failed hold until reset
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (in_hps_rst) begin
            state_q  <= ST_LOAD;
            cursor_q <= '0;
        end else begin
            state_q  <= state_d;
            cursor_q <= cursor_d;
        end
    end

    always_comb begin
        case (state_q)
            ST_SOLVED: o_status = STATUS_SOLVED;
            ST_FAILED: o_status = STATUS_FAILED;
            default:   o_status = STATUS_BUSY;
        endcase
    end

endmodule

`default_nettype wire

// File: src/sudoku_solver.sv
`default_nettype none

module sudoku_solver (
    input  wire                        clk,
    input  wire                        in_hps_rst,
    input  wire                        i_load_valid,
    input  wire sudoku_pkg::cell_idx_t i_load_addr,
    input  wire sudoku_pkg::digit_t    i_load_value,
    input  wire sudoku_pkg::cell_idx_t i_read_idx,
    output sudoku_pkg::digit_t         o_read_value,
    output sudoku_pkg::status_e        o_status
);
    import sudoku_pkg::*;

    logic      append;
    list_ptr_t cursor;
    list_ptr_t count;
    cell_idx_t entry;
    cell_idx_t probe_idx;
    digit_t    probe_value;
    board_t    board;
    logic      conflict;
    logic      wr_en;
    cell_idx_t wr_idx;
    digit_t    wr_value;
    logic      export_en;

    backtrack_engine u_engine (
        .clk           (clk),
        .in_hps_rst    (in_hps_rst),
        .i_load_valid  (i_load_valid),
        .i_load_addr   (i_load_addr),
        .i_load_value  (i_load_value),
        .i_count       (count),
        .i_entry       (entry),
        .i_probe_value (probe_value),
        .i_conflict    (conflict),
        .o_append      (append),
        .o_cursor      (cursor),
        .o_probe_idx   (probe_idx),
        .o_wr_en       (wr_en),
        .o_wr_idx      (wr_idx),
        .o_wr_value    (wr_value),
        .o_export_en   (export_en),
        .o_status      (o_status)
    );

    empty_cell_list u_empty_list (
        .clk          (clk),
        .in_hps_rst   (in_hps_rst),
        .i_append     (append),
        .i_append_idx (i_load_addr), // address of the blank being loaded
        .i_cursor     (cursor),
        .o_entry      (entry),
        .o_count      (count)
    );

    grid_store u_grid (
        .clk           (clk),
        .in_hps_rst    (in_hps_rst),
        .i_wr_en       (wr_en),
        .i_wr_idx      (wr_idx),
        .i_wr_value    (wr_value),
        .i_probe_idx   (probe_idx),
        .i_read_idx    (i_read_idx),
        .i_export_en   (export_en),
        .o_probe_value (probe_value),
        .o_board       (board),
        .o_read_value  (o_read_value)
    );

    conflict_check u_check (
        .i_board     (board),
        .i_probe_idx (probe_idx),
        .o_conflict  (conflict)
    );

endmodule

`default_nettype wire

// File: verif/sudoku_solver_properties.sv
`default_nettype none

module sudoku_solver_properties (
    input wire                            clk,
    input wire                            in_hps_rst,
    input wire sudoku_pkg::engine_state_e i_state,
    input wire sudoku_pkg::status_e       i_status,
    input wire                            i_wr_en,
    input wire sudoku_pkg::list_ptr_t     i_cursor,
    input wire sudoku_pkg::list_ptr_t     i_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import sudoku_pkg::*;

    int fail_count = 0;

    // solved and failed only clear through reset
    status_held: assert property (
        @(posedge clk) disable iff (in_hps_rst)
        (i_status != STATUS_BUSY) |=> (i_status == $past(i_status))
    ) else begin
        $error("status left solved or failed without reset");
        fail_count++;
    end

    no_write_when_done: assert property (
        @(posedge clk) disable iff (in_hps_rst)
        (i_status != STATUS_BUSY) |-> !i_wr_en
    ) else begin
        $error("grid write after the search ended");
        fail_count++;
    end

    cursor_in_list: assert property (
        @(posedge clk) disable iff (in_hps_rst)
        (i_state inside {ST_STEP, ST_CHECK}) |-> (i_cursor < i_count)
    ) else begin
        $error("search cursor ran past the blank count");
        fail_count++;
    end

endmodule

bind backtrack_engine sudoku_solver_properties u_props (
    .clk        (clk),
    .in_hps_rst (in_hps_rst),
    .i_state    (state_q),
    .i_status   (o_status),
    .i_wr_en    (o_wr_en),
    .i_cursor   (o_cursor),
    .i_count    (i_count)
);

`default_nettype wire

// File: verif/tb_sudoku_solver.sv
`default_nettype none

module tb_sudoku_solver;
    timeunit 1ns;
    timeprecision 100ps;
    import sudoku_pkg::*;

    localparam int LOADS        = 5;
    localparam int SOLVE_CYCLES = 50000;
    localparam int LOAD_CYCLES  = 100;
    localparam int READ_CYCLES  = 100;
    localparam int CYCLE_LIMIT  = LOADS * (SOLVE_CYCLES + LOAD_CYCLES + READ_CYCLES);
    localparam int BLANKS       = 20;

    logic      clk;
    logic      in_hps_rst;
    logic      i_load_valid;
    cell_idx_t i_load_addr;
    digit_t    i_load_value;
    cell_idx_t i_read_idx;
    digit_t    o_read_value;
    status_e   o_status;

    digit_t      solution [CELLS];
    digit_t      puzzle_a [CELLS]; // solution with random blanks
    digit_t      stim     [CELLS];
    digit_t      rdback   [CELLS];
    logic [31:0] lfsr_q;
    int          err_count;
    int          test_errs;
    int          prop_errs;
    int          tests_run;
    int          cycle_count = 0;
    status_e     end_status;

    sudoku_solver dut0 (
        .clk          (clk),
        .in_hps_rst   (in_hps_rst),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_value (i_load_value),
        .i_read_idx   (i_read_idx),
        .o_read_value (o_read_value),
        .o_status     (o_status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin : watchdog
        wait (cycle_count >= CYCLE_LIMIT);
        $display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic build_solution();
        for (int r = 0; r < SIDE; r++) begin
            for (int c = 0; c < SIDE; c++) begin
                solution[r * SIDE + c] = digit_t'((r * BOX + r / BOX + c) % SIDE + 1);
            end
        end
    endtask

    task automatic make_puzzle();
        int idx;
        int blanks;
        puzzle_a = solution;
        blanks   = 0;
        while (blanks < BLANKS) begin
            draw_bits(7, idx);
            if (idx < CELLS && puzzle_a[idx] != '0) begin
                puzzle_a[idx] = '0;
                blanks++;
            end
        end
    endtask

    task automatic check_cell(input int idx, input digit_t got, input digit_t exp);
        assert (got == exp) else begin
            $display("** Error at %0t: o_read_value[%0d] = %0d, expected %0d",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_busy_read();
        check_cell(int'(i_read_idx), o_read_value, '0);
    endtask

    task automatic check_status(input status_e exp);
        assert (end_status == exp) else begin
            $display("** Error at %0t: o_status = %0d, expected %0d", $time, end_status, exp);
            err_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        in_hps_rst   = 1'b1;
        i_load_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1 in_hps_rst = 1'b0;
    endtask

    // 81 cell writes, then the end strobe at address 81
    task automatic load_puzzle();
        for (int a = 0; a <= CELLS; a++) begin
            @(posedge clk);
            #1;
            i_load_valid = 1'b1;
            i_load_addr  = cell_idx_t'(a);
            i_load_value = (a < CELLS) ? stim[a] : '0;
            i_read_idx   = (a == 0) ? '0 : cell_idx_t'(a - 1); // already written
            @(negedge clk);
            check_busy_read();
        end
        @(posedge clk);
        #1 i_load_valid = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (o_status == STATUS_BUSY && waited < SOLVE_CYCLES) begin
            check_busy_read();
            @(posedge clk);
            #1 i_read_idx = cell_idx_t'(waited % CELLS);
            waited++;
            @(negedge clk);
        end
        end_status = o_status;
        assert (o_status != STATUS_BUSY) else begin
            $display("search did not finish within %0d cycles", SOLVE_CYCLES);
            err_count++;
        end
    endtask

    task automatic read_board();
        for (int i = 0; i < CELLS; i++) begin
            @(posedge clk);
            #1 i_read_idx = cell_idx_t'(i);
            @(negedge clk);
            rdback[i] = o_read_value;
        end
    endtask

    task automatic check_givens();
        for (int i = 0; i < CELLS; i++) begin
            if (puzzle_a[i] != '0) begin
                check_cell(i, rdback[i], puzzle_a[i]);
            end
        end
    endtask

    task automatic check_grid_valid();
        logic [9:0] row_m;
        logic [9:0] col_m;
        logic [9:0] box_m;
        int         box_idx;
        for (int u = 0; u < SIDE; u++) begin
            row_m = '0;
            col_m = '0;
            box_m = '0;
            for (int k = 0; k < SIDE; k++) begin
                box_idx = ((u / BOX) * BOX + k / BOX) * SIDE + (u % BOX) * BOX + k % BOX;
                row_m[rdback[u * SIDE + k]] = 1'b1;
                col_m[rdback[k * SIDE + u]] = 1'b1;
                box_m[rdback[box_idx]]      = 1'b1;
            end
            // bit 0 set means a blank was left
            assert (row_m == 10'h3fe) else begin
                $display("row %0d does not hold 1 through 9 once each", u);
                err_count++;
            end
            assert (col_m == 10'h3fe) else begin
                $display("column %0d does not hold 1 through 9 once each", u);
                err_count++;
            end
            assert (box_m == 10'h3fe) else begin
                $display("box %0d does not hold 1 through 9 once each", u);
                err_count++;
            end
        end
    endtask

    task automatic report_test(input string name);
        int new_props;
        new_props  = dut0.u_engine.u_props.fail_count - prop_errs;
        prop_errs += new_props;
        err_count += new_props;
        tests_run++;
        $display("[%0d] %s: %0d errors", tests_run, name, err_count - test_errs);
    endtask

    task automatic test_random_blanks();
        test_errs = err_count;
        apply_reset();
        stim = puzzle_a;
        load_puzzle();
        wait_done();
        check_status(STATUS_SOLVED);
        read_board();
        check_givens();
        check_grid_valid();
        report_test("random blanks solve");
    endtask

    task automatic test_full_grid();
        test_errs = err_count;
        apply_reset();
        stim = solution;
        load_puzzle();
        wait_done();
        check_status(STATUS_SOLVED);
        read_board();
        for (int i = 0; i < CELLS; i++) begin
            check_cell(i, rdback[i], solution[i]);
        end
        report_test("full grid");
    endtask

    task automatic test_busy_readback();
        test_errs = err_count;
        apply_reset();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1 i_read_idx = cell_idx_t'(i * 17);
            @(negedge clk);
            check_busy_read();
        end
        stim = puzzle_a;
        load_puzzle(); // load and search both check the readback
        wait_done();
        check_status(STATUS_SOLVED);
        report_test("busy readback");
    endtask

    task automatic test_no_fit();
        test_errs = err_count;
        apply_reset();
        stim           = solution;
        stim[0]        = '0;
        stim[4 * SIDE] = solution[0]; // missing digit now sits in column 0
        load_puzzle();
        wait_done();
        check_status(STATUS_FAILED);
        read_board();
        for (int i = 0; i < CELLS; i++) begin
            check_cell(i, rdback[i], '0);
        end
        report_test("unsolvable puzzle");
    endtask

    task automatic test_reset_reload();
        test_errs = err_count;
        apply_reset();
        @(negedge clk);
        end_status = o_status;
        check_status(STATUS_BUSY);
        stim = puzzle_a;
        load_puzzle();
        wait_done();
        check_status(STATUS_SOLVED);
        read_board();
        check_givens();
        check_grid_valid();
        report_test("reset after fail");
    endtask

    initial begin
        in_hps_rst   = 1'b1;
        i_load_valid = 1'b0;
        i_load_addr  = '0;
        i_load_value = '0;
        i_read_idx   = '0;
        err_count    = 0;
        test_errs    = 0;
        prop_errs    = 0;
        tests_run    = 0;
        lfsr_q       = 32'h9204_8af6;
        build_solution();
        make_puzzle();

        test_random_blanks();
        test_full_grid();
        test_busy_readback();
        test_no_fit();
        test_reset_reload();

        $display("%0d tests run, %0d errors", tests_run, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/sudoku_pkg.sv
src/grid_store.sv
src/conflict_check.sv
src/empty_cell_list.sv
src/backtrack_engine.sv
src/sudoku_solver.sv
verif/sudoku_solver_properties.sv
verif/tb_sudoku_solver.sv

// File: Bender.yml
package:
  name: sudoku_solver

sources:
  - src/sudoku_pkg.sv
  - src/grid_store.sv
  - src/conflict_check.sv
  - src/empty_cell_list.sv
  - src/backtrack_engine.sv
  - src/sudoku_solver.sv
  - target: test
    files:
      - verif/sudoku_solver_properties.sv
      - verif/tb_sudoku_solver.sv
